// File: bench/mem_subsystem_asserts.sv
`timescale 1ns/1ps

module mem_subsystem_asserts (
    input logic               clk_i,
    input logic               rst_i,
    input logic               req_valid0_i,
    input logic               req_ready0_o,
    input mem_pkg::mem_req_t  req0_i,
    input logic               resp_valid0_o,
    input logic               resp_ready0_i,
    input mem_pkg::mem_resp_t resp0_o,
    input logic               req_valid1_i,
    input logic               req_ready1_o,
    input mem_pkg::mem_req_t  req1_i,
    input logic               resp_valid1_o,
    input logic               resp_ready1_i,
    input mem_pkg::mem_resp_t resp1_o,
    input logic               bus_valid0,
    input logic               bus_grant0,
    input mem_pkg::bus_req_t  bus_req0,
    input logic               bus_valid1,
    input logic               bus_grant1,
    input mem_pkg::bus_req_t  bus_req1
);

    a_req0_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid0_i && !req_ready0_o |=> req_valid0_i && $stable(req0_i))
        else $error("Port 0 request changed before acceptance");
    a_req1_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid1_i && !req_ready1_o |=> req_valid1_i && $stable(req1_i))
        else $error("Port 1 request changed before acceptance");
    a_resp0_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid0_o && !resp_ready0_i |=> resp_valid0_o && $stable(resp0_o))
        else $error("Port 0 response changed before acceptance");
    a_resp1_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid1_o && !resp_ready1_i |=> resp_valid1_o && $stable(resp1_o))
        else $error("Port 1 response changed before acceptance");
    a_bus0_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_valid0 && !bus_grant0 |=> bus_valid0 && $stable(bus_req0))
        else $error("Port 0 bus request changed before grant");
    a_bus1_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_valid1 && !bus_grant1 |=> bus_valid1 && $stable(bus_req1))
        else $error("Port 1 bus request changed before grant");

    a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        !(bus_grant0 && bus_grant1))
        else $error("Both ports granted in one cycle");

    a_reset_quiet: assert property (@(posedge clk_i)
        rst_i |=> !resp_valid0_o && !resp_valid1_o)
        else $error("Response valid right after reset");

endmodule

bind mem_subsystem_top mem_subsystem_asserts u_asserts (.*);

// File: bench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam logic [31:0] LFSR_SEED = 32'h6c2f_5211;
    localparam int RAND_OPS        = 120;
    localparam int OPS_PER_PORT    = 101 + RAND_OPS;   // Directed passes plus random mix
    localparam int WATCHDOG_CYCLES = 2 * OPS_PER_PORT * 40;

    logic               clk;
    logic               rst;
    logic               req_valid [2];
    logic               req_ready [2];
    mem_pkg::mem_req_t  req [2];
    logic               resp_valid [2];
    logic               resp_ready [2];
    mem_pkg::mem_resp_t resp [2];
    logic               bp_en [2];         // Random response back-pressure

    logic [7:0]         model_mem [1024];  // Byte image of the RAM
    mem_pkg::mem_resp_t exp_q0 [$];
    mem_pkg::mem_resp_t exp_q1 [$];
    logic [31:0]        lfsr_q [3];        // One stream per stimulus process
    int                 errors;
    int                 issued;
    int                 checked;

    mem_subsystem_top uut (
        .clk_i         (clk),
        .rst_i         (rst),
        .req_valid0_i  (req_valid[0]),
        .req_ready0_o  (req_ready[0]),
        .req0_i        (req[0]),
        .resp_valid0_o (resp_valid[0]),
        .resp_ready0_i (resp_ready[0]),
        .resp0_o       (resp[0]),
        .req_valid1_i  (req_valid[1]),
        .req_ready1_o  (req_ready[1]),
        .req1_i        (req[1]),
        .resp_valid1_o (resp_valid[1]),
        .resp_ready1_i (resp_ready[1]),
        .resp1_o       (resp[1])
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] st);
        return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q[s] = lfsr_next(lfsr_q[s]);
            v = {v[30:0], lfsr_q[s][0]};
        end
        return v;
    endfunction

    function automatic mem_pkg::addr_t word_addr(input int p, input int w, input int off);
        return mem_pkg::addr_t'(p * 64 + w * 4 + off);   // 16 words per port
    endfunction

    function automatic int outstanding();
        return exp_q0.size() + exp_q1.size();
    endfunction

    // Applies a request to the byte model and returns the response it should get
    function automatic mem_pkg::mem_resp_t model_access(input mem_pkg::mem_req_t r);
        int                 a;
        logic               mem_op;
        logic               bad;
        mem_pkg::mem_resp_t e;
        a      = int'(r.addr[9:0]);
        mem_op = (r.op == mem_pkg::OP_LOAD) || (r.op == mem_pkg::OP_STORE);
        case (r.sz)
            mem_pkg::SZ_HALF: bad = mem_op && (a % 2 != 0);
            mem_pkg::SZ_WORD: bad = mem_op && (a % 4 != 0);
            default:          bad = 1'b0;
        endcase
        e.data      = r.wdata;
        e.align_err = bad;
        if (!bad && r.op == mem_pkg::OP_STORE) begin
            model_mem[a] = r.wdata[7:0];
            if (r.sz != mem_pkg::SZ_BYTE) begin
                model_mem[a + 1] = r.wdata[15:8];
            end
            if (r.sz == mem_pkg::SZ_WORD) begin
                model_mem[a + 2] = r.wdata[23:16];
                model_mem[a + 3] = r.wdata[31:24];
            end
        end else if (!bad && r.op == mem_pkg::OP_LOAD) begin
            case (r.sz)
                mem_pkg::SZ_BYTE: begin
                    e.data = {24'h0, model_mem[a]};
                    if (!r.is_unsigned) e.data[31:8] = {24{model_mem[a][7]}};
                end
                mem_pkg::SZ_HALF: begin
                    e.data = {16'h0, model_mem[a + 1], model_mem[a]};
                    if (!r.is_unsigned) e.data[31:16] = {16{model_mem[a + 1][7]}};
                end
                default:
                    e.data = {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
            endcase
        end
        return e;
    endfunction

    task automatic send_req(input int p, input mem_pkg::mem_req_t r);
        logic taken;
        req[p]       = r;
        req_valid[p] = 1'b1;
        taken        = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready[p];
            @(posedge clk);
            #1;
        end
        req_valid[p] = 1'b0;
    endtask

    task automatic do_access(input int p, input mem_pkg::access_op_e op,
                             input mem_pkg::access_sz_e sz, input logic uns,
                             input mem_pkg::addr_t addr, input mem_pkg::data_t wdata);
        mem_pkg::mem_req_t r;
        r.op          = op;
        r.sz          = sz;
        r.is_unsigned = uns;
        r.addr        = addr;
        r.wdata       = wdata;
        if (p == 0) exp_q0.push_back(model_access(r));
        else exp_q1.push_back(model_access(r));
        issued++;
        send_req(p, r);
    endtask

    task automatic store_at(input int p, input mem_pkg::access_sz_e sz,
                            input mem_pkg::addr_t addr);
        do_access(p, mem_pkg::OP_STORE, sz, 1'b0, addr, rand_bits(p, 32));
    endtask

    task automatic load_at(input int p, input mem_pkg::access_sz_e sz, input logic uns,
                           input mem_pkg::addr_t addr);
        do_access(p, mem_pkg::OP_LOAD, sz, uns, addr, rand_bits(p, 32));   // wdata must not leak
    endtask

    task automatic run_port(input int p);
        logic [31:0]         sel;
        logic [31:0]         up;
        int                  off;
        mem_pkg::access_op_e op;
        mem_pkg::access_sz_e sz;
        for (int w = 0; w < 16; w++) store_at(p, mem_pkg::SZ_WORD, word_addr(p, w, 0));
        for (int w = 0; w < 16; w++) load_at(p, mem_pkg::SZ_WORD, 1'b0, word_addr(p, w, 0));
        // Narrow stores, then word loads to see untouched lanes
        for (int w = 0; w < 16; w++) begin
            sel = rand_bits(p, 3);
            if (sel[0]) store_at(p, mem_pkg::SZ_HALF, word_addr(p, w, 2 * int'(sel[1])));
            else store_at(p, mem_pkg::SZ_BYTE, word_addr(p, w, int'(sel[2:1])));
        end
        for (int w = 0; w < 16; w++) load_at(p, mem_pkg::SZ_WORD, 1'b0, word_addr(p, w, 0));
        for (int w = 2; w < 10; w += 7) begin
            for (int o = 0; o < 4; o++) begin
                load_at(p, mem_pkg::SZ_BYTE, 1'b0, word_addr(p, w, o));
                load_at(p, mem_pkg::SZ_BYTE, 1'b1, word_addr(p, w, o));
            end
            for (int o = 0; o < 4; o += 2) begin
                load_at(p, mem_pkg::SZ_HALF, 1'b0, word_addr(p, w, o));
                load_at(p, mem_pkg::SZ_HALF, 1'b1, word_addr(p, w, o));
            end
        end
        // Misaligned and pass accesses must leave word 5 alone
        for (int o = 1; o < 4; o++) begin
            store_at(p, mem_pkg::SZ_WORD, word_addr(p, 5, o));
            load_at(p, mem_pkg::SZ_WORD, 1'b0, word_addr(p, 5, o));
        end
        for (int o = 1; o < 4; o += 2) begin
            store_at(p, mem_pkg::SZ_HALF, word_addr(p, 5, o));
            load_at(p, mem_pkg::SZ_HALF, 1'b1, word_addr(p, 5, o));
        end
        do_access(p, mem_pkg::OP_PASS, mem_pkg::SZ_WORD, 1'b0, word_addr(p, 5, 1),
                  rand_bits(p, 32));
        do_access(p, mem_pkg::OP_PASS, mem_pkg::SZ_HALF, 1'b1, word_addr(p, 5, 3),
                  rand_bits(p, 32));
        load_at(p, mem_pkg::SZ_WORD, 1'b0, word_addr(p, 5, 0));
        bp_en[p] = 1'b1;
        for (int i = 0; i < RAND_OPS; i++) begin
            sel = rand_bits(p, 6);
            case (sel[1:0])
                2'd0:    op = mem_pkg::OP_PASS;
                2'd2:    op = mem_pkg::OP_STORE;
                default: op = mem_pkg::OP_LOAD;
            endcase
            case (sel[3:2])
                2'd0:    sz = mem_pkg::SZ_BYTE;
                2'd1:    sz = mem_pkg::SZ_HALF;
                default: sz = mem_pkg::SZ_WORD;
            endcase
            off = int'(rand_bits(p, 6));
            if (sel[5:4] != 2'd0 && sz == mem_pkg::SZ_WORD) off = off & ~3;   // Mostly aligned
            if (sel[5:4] != 2'd0 && sz == mem_pkg::SZ_HALF) off = off & ~1;
            up = rand_bits(p, 22) << 10;   // Bits above 1 KB
            do_access(p, op, sz, rand_bits(p, 1) != 0, up | word_addr(p, 0, off),
                      rand_bits(p, 32));
            repeat (rand_bits(p, 2)) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic watch_resp(input int p);
        mem_pkg::mem_resp_t got;
        mem_pkg::mem_resp_t exp;
        logic               have;
        forever begin
            @(negedge clk);
            if (resp_valid[p] && resp_ready[p]) begin
                got  = resp[p];
                have = 1'b1;
                if (p == 0 && exp_q0.size() != 0) exp = exp_q0.pop_front();
                else if (p == 1 && exp_q1.size() != 0) exp = exp_q1.pop_front();
                else have = 1'b0;
                checked++;
                if (!have) begin
                    $display("Port %0d returned a response with no request outstanding", p);
                    errors++;
                end else begin
                    if (got.data !== exp.data) begin
                        $display("CHECK FAILED resp%0d_o.data: expected %h, got %h at %0t",
                                 p, exp.data, got.data, $time);
                        errors++;
                    end
                    if (got.align_err !== exp.align_err) begin
                        $display("CHECK FAILED resp%0d_o.align_err: expected %h, got %h at %0t",
                                 p, exp.align_err, got.align_err, $time);
                        errors++;
                    end
                end
            end
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d errors, %0d requests, %0d responses", errors, issued, checked);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            resp_ready[0] = !bp_en[0] || (rand_bits(2, 2) != 0);
            resp_ready[1] = !bp_en[1] || (rand_bits(2, 2) != 0);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d responses outstanding",
                 WATCHDOG_CYCLES, outstanding());
        print_summary();
        $display("Test failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        lfsr_q[0] = LFSR_SEED;
        lfsr_q[1] = LFSR_SEED ^ 32'h0000_0001;
        lfsr_q[2] = LFSR_SEED ^ 32'h0000_0002;
        errors    = 0;
        issued    = 0;
        checked   = 0;
        for (int p = 0; p < 2; p++) begin
            req_valid[p]  = 1'b0;
            req[p]        = '0;
            resp_ready[p] = 1'b1;
            bp_en[p]      = 1'b0;
        end
        fork
            watch_resp(0);
            watch_resp(1);
        join_none
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            run_port(0);
            run_port(1);
        join
        while (outstanding() != 0) @(posedge clk);
        repeat (4) @(posedge clk);   // Room for any stray response
        if (checked != issued) begin
            $display("Got %0d responses for %0d requests", checked, issued);
            errors++;
        end
        print_summary();
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              bus_valid0_i,
    input  mem_pkg::bus_req_t bus_req0_i,
    output logic              bus_grant0_o,
    input  logic              bus_valid1_i,
    input  mem_pkg::bus_req_t bus_req1_i,
    output logic              bus_grant1_o,
    output logic              ram_en_o,
    output mem_pkg::bus_req_t ram_req_o,
    input  mem_pkg::data_t    ram_rdata_i,
    output logic              rd_valid0_o,
    output logic              rd_valid1_o,
    output mem_pkg::data_t    rd_data_o
);

    logic last_q;       // Port granted most recently
    logic rd_pend_q;    // Read issued last cycle
    logic owner_q;      // Port that owns the pending read

    // Tie goes to the port not granted last time
    assign bus_grant0_o = bus_valid0_i && (!bus_valid1_i || last_q);
    assign bus_grant1_o = bus_valid1_i && (!bus_valid0_i || !last_q);

    assign ram_en_o  = bus_grant0_o || bus_grant1_o;
    assign ram_req_o = bus_grant1_o ? bus_req1_i : bus_req0_i;

    // Read data comes back one cycle after the grant
    assign rd_valid0_o = rd_pend_q && !owner_q;
    assign rd_valid1_o = rd_pend_q && owner_q;
    assign rd_data_o   = ram_rdata_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q    <= 1'b1;    // Port 0 wins first tie
            rd_pend_q <= 1'b0;
            owner_q   <= 1'b0;
        end else begin
            rd_pend_q <= ram_en_o && !ram_req_o.we;
            if (ram_en_o) begin
                last_q  <= bus_grant1_o;
                owner_q <= bus_grant1_o;
            end
        end
    end

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic              clk_i,
    input  logic              en_i,
    input  mem_pkg::bus_req_t req_i,
    output mem_pkg::data_t    rdata_o
);

    mem_pkg::data_t mem_q [mem_pkg::RAM_WORDS];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (req_i.we) begin
                for (int i = 0; i < $bits(mem_pkg::byte_en_t); i++) begin
                    if (req_i.be[i]) begin
                        mem_q[req_i.idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
                    end
                end
            end
            rdata_o <= mem_q[req_i.idx];   // Old contents on a write
        end
    end

endmodule

// File: hw/mem_access_unit.sv
`timescale 1ns/1ps

module mem_access_unit (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  mem_pkg::mem_req_t  req_i,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output mem_pkg::mem_resp_t resp_o,
    output logic               bus_valid_o,
    output mem_pkg::bus_req_t  bus_req_o,
    input  logic               bus_grant_i,
    input  logic               rd_valid_i,
    input  mem_pkg::data_t     rd_data_i
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        WAIT,
        RESP
    } state_e;

    state_e             state_q;
    mem_pkg::mem_req_t  req_q;
    mem_pkg::data_t     resp_data_q;
    logic               align_err_q;

    logic               accept;
    logic               is_mem_op;
    logic               misaligned;
    mem_pkg::byte_en_t  byte_en;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;
    mem_pkg::data_t     ld_data;

    assign req_ready_o  = (state_q == IDLE);
    assign resp_valid_o = (state_q == RESP);
    assign bus_valid_o  = (state_q == BUS);
    assign accept       = req_valid_i && req_ready_o;

    assign resp_o.data      = resp_data_q;
    assign resp_o.align_err = align_err_q;

    // Alignment check on the incoming request
    always_comb begin
        is_mem_op = (req_i.op == mem_pkg::OP_LOAD) || (req_i.op == mem_pkg::OP_STORE);
        case (req_i.sz)
            mem_pkg::SZ_BYTE: misaligned = 1'b0;
            mem_pkg::SZ_HALF: misaligned = is_mem_op && req_i.addr[0];
            default:          misaligned = is_mem_op && (req_i.addr[1:0] != 2'b00);
        endcase
    end

    always_comb begin
        case (req_q.sz)
            mem_pkg::SZ_BYTE: byte_en = 4'b0001 << req_q.addr[1:0];
            mem_pkg::SZ_HALF: byte_en = req_q.addr[1] ? 4'b1100 : 4'b0011;
            default:          byte_en = 4'b1111;
        endcase
    end

    always_comb begin
        bus_req_o.idx = req_q.addr[9:2];            // Bits above 1 KB ignored
        bus_req_o.we  = (req_q.op == mem_pkg::OP_STORE);
        bus_req_o.be  = byte_en;
        case (req_q.sz)
            mem_pkg::SZ_BYTE: bus_req_o.wdata = {4{req_q.wdata[7:0]}};
            mem_pkg::SZ_HALF: bus_req_o.wdata = {2{req_q.wdata[15:0]}};
            default:          bus_req_o.wdata = req_q.wdata;
        endcase
    end

    // Load lane select and extension
    always_comb begin
        ld_half = req_q.addr[1] ? rd_data_i[31:16] : rd_data_i[15:0];
        ld_byte = rd_data_i[{req_q.addr[1:0], 3'b000} +: 8];
        case (req_q.sz)
            mem_pkg::SZ_BYTE:
                ld_data = req_q.is_unsigned ? {24'b0, ld_byte} : {{24{ld_byte[7]}}, ld_byte};
            mem_pkg::SZ_HALF:
                ld_data = req_q.is_unsigned ? {16'b0, ld_half} : {{16{ld_half[15]}}, ld_half};
            default:
                ld_data = rd_data_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (accept) begin
                    state_q <= (is_mem_op && !misaligned) ? BUS : RESP;
                end
                BUS:  if (bus_grant_i) begin
                    state_q <= bus_req_o.we ? RESP : WAIT;   // Stores need no read data
                end
                WAIT: if (rd_valid_i) begin
                    state_q <= RESP;
                end
                RESP: if (resp_ready_i) begin
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q       <= req_i;
            resp_data_q <= req_i.wdata;   // Echoed unless a load overwrites it
            align_err_q <= misaligned;
        end else if (state_q == WAIT && rd_valid_i) begin
            resp_data_q <= ld_data;
        end
    end

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_en_t;   // One enable per byte lane
    typedef logic [7:0]  word_idx_t;  // RAM word index
    typedef data_t       bus_rsp_t;   // RAM read data

    localparam int RAM_WORDS = 256;   // 1 KB of data memory

    typedef enum logic [1:0] {
        OP_PASS  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } access_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } access_sz_e;

    // Port request
    typedef struct packed {
        access_op_e op;
        access_sz_e sz;
        logic       is_unsigned;
        addr_t      addr;
        data_t      wdata;
    } mem_req_t;

    // Port response
    typedef struct packed {
        data_t data;
        logic  align_err;
    } mem_resp_t;

    // Shared RAM bus request
    typedef struct packed {
        word_idx_t idx;
        logic      we;
        byte_en_t  be;
        data_t     wdata;     // Already replicated across lanes
    } bus_req_t;

endpackage

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               req_valid0_i,
    output logic               req_ready0_o,
    input  mem_pkg::mem_req_t  req0_i,
    output logic               resp_valid0_o,
    input  logic               resp_ready0_i,
    output mem_pkg::mem_resp_t resp0_o,
    input  logic               req_valid1_i,
    output logic               req_ready1_o,
    input  mem_pkg::mem_req_t  req1_i,
    output logic               resp_valid1_o,
    input  logic               resp_ready1_i,
    output mem_pkg::mem_resp_t resp1_o
);

    logic              bus_valid0;
    logic              bus_valid1;
    mem_pkg::bus_req_t bus_req0;
    mem_pkg::bus_req_t bus_req1;
    logic              bus_grant0;
    logic              bus_grant1;
    logic              rd_valid0;
    logic              rd_valid1;
    mem_pkg::bus_rsp_t rd_data;     // Shared by both ports
    logic              ram_en;
    mem_pkg::bus_req_t ram_req;
    mem_pkg::bus_rsp_t ram_rdata;

    mem_access_unit u_port0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid0_i),
        .req_ready_o  (req_ready0_o),
        .req_i        (req0_i),
        .resp_valid_o (resp_valid0_o),
        .resp_ready_i (resp_ready0_i),
        .resp_o       (resp0_o),
        .bus_valid_o  (bus_valid0),
        .bus_req_o    (bus_req0),
        .bus_grant_i  (bus_grant0),
        .rd_valid_i   (rd_valid0),
        .rd_data_i    (rd_data)
    );

    mem_access_unit u_port1 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid1_i),
        .req_ready_o  (req_ready1_o),
        .req_i        (req1_i),
        .resp_valid_o (resp_valid1_o),
        .resp_ready_i (resp_ready1_i),
        .resp_o       (resp1_o),
        .bus_valid_o  (bus_valid1),
        .bus_req_o    (bus_req1),
        .bus_grant_i  (bus_grant1),
        .rd_valid_i   (rd_valid1),
        .rd_data_i    (rd_data)
    );

    bus_arbiter u_arb (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_valid0_i (bus_valid0),
        .bus_req0_i   (bus_req0),
        .bus_grant0_o (bus_grant0),
        .bus_valid1_i (bus_valid1),
        .bus_req1_i   (bus_req1),
        .bus_grant1_o (bus_grant1),
        .ram_en_o     (ram_en),
        .ram_req_o    (ram_req),
        .ram_rdata_i  (ram_rdata),
        .rd_valid0_o  (rd_valid0),
        .rd_valid1_o  (rd_valid1),
        .rd_data_o    (rd_data)
    );

    data_ram u_ram (
        .clk_i   (clk_i),
        .en_i    (ram_en),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem -f tb.f \
    && ./obj_dir/Vtb_mem_subsystem > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation ended abnormally"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || { echo "No result line found in sim.log"; exit 1; }
exit 0

// File: tb.f
hw/mem_pkg.sv
hw/data_ram.sv
hw/bus_arbiter.sv
hw/mem_access_unit.sv
hw/mem_subsystem_top.sv
bench/mem_subsystem_asserts.sv
bench/tb_mem_subsystem.sv
